/* hw/bypass_pkg.sv */
package bypass_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Line addressing
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 10;
    localparam int LINES      = 1 << ADDR_W;
    localparam int ID_W       = 16;
    localparam int BEATS      = 4;
    localparam int OFFSET_W   = $clog2(BEATS);
    localparam int DATA_W     = 64;

    // Fill count reaches this once a whole line has arrived
    localparam int COUNT_W    = 8;
    localparam int LINE_BYTES = 64;

    ////////////////////////////////////////////////////////////////////////////
    // Metadata word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int META_W     = 32;
    localparam int ID_LSB     = 0;
    localparam int COUNT_LSB  = 16;
    localparam int OFFSET_LSB = 24;

    // Configuration and fetch side widths
    localparam int ROWS_W     = 32;
    localparam int COLW_W     = 16;
    localparam int SIZE_W     = 8;

    // Engine states, same encoding on both sides
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
    localparam logic [STATE_W-1:0] ST_LOOKUP = 3'd1;
    localparam logic [STATE_W-1:0] ST_DECIDE = 3'd2;
    localparam logic [STATE_W-1:0] ST_CLEAR  = 3'd3;
    localparam logic [STATE_W-1:0] ST_WAIT   = 3'd4;

endpackage

/* hw/line_table.sv */
module line_table
    import bypass_pkg::*;
(
    input  logic              clock,
    // Port A, request side
    input  logic [ADDR_W-1:0] a_addr,
    input  logic              a_we,
    input  logic [META_W-1:0] a_wdata,
    output logic [META_W-1:0] a_rdata,
    // Port B, fill side
    input  logic [ADDR_W-1:0] b_addr,
    input  logic              b_we,
    input  logic [META_W-1:0] b_wdata,
    output logic [META_W-1:0] b_rdata
);

    logic [META_W-1:0] mem [0:LINES-1];

    // Every line starts empty with no requester pending
    initial
    begin
        for (int i = 0; i < LINES; i++)
        begin
            mem[i] = '0;
        end
    end

    // Both ports in one process so the array has a single writer
    // Reads return the word as it was before the edge
    always @(posedge clock)
    begin
        if (a_we)
        begin
            mem[a_addr] <= a_wdata;
        end
        if (b_we)
        begin
            mem[b_addr] <= b_wdata;
        end
        a_rdata <= mem[a_addr];
        b_rdata <= mem[b_addr];
    end

endmodule

/* hw/line_store.sv */
module line_store
    import bypass_pkg::*;
(
    input  logic              clock,
    // Write side, driven by the fetch unit
    input  logic              fill_en,
    input  logic [ADDR_W-1:0] fill_addr,
    input  logic [DATA_W-1:0] fill_data,
    // Read side, driven by the request engine
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [0:LINES-1];

    // Whole word per write
    always_ff @(posedge clock)
    begin
        if (fill_en)
        begin
            mem[fill_addr] <= fill_data;
        end
    end

    // Registered read of the held request address
    always_ff @(posedge clock)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/request_engine.sv */
module request_engine
    import bypass_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    // Request notifications
    input  logic                request_valid,
    input  logic [ADDR_W-1:0]   request_addr,
    input  logic [ID_W-1:0]     request_id,
    input  logic [OFFSET_W-1:0] request_offset,
    // Table geometry
    input  logic [ROWS_W-1:0]   row_count,
    input  logic [COLW_W-1:0]   col_width,
    // Memory read data
    input  logic [META_W-1:0]   a_rdata,
    input  logic [DATA_W-1:0]   store_rdata,
    // From the fill engine
    input  logic [ADDR_W-1:0]   fill_addr_held,
    input  logic                fill_quiet,
    // Table port A
    output logic [ADDR_W-1:0]   a_addr,
    output logic                a_we,
    output logic [META_W-1:0]   a_wdata,
    // To the fill engine
    output logic [ADDR_W-1:0]   req_addr_held,
    output logic                req_lookup,
    output logic                req_quiet,
    // Availability notification
    output logic                notify_valid,
    output logic [ADDR_W-1:0]   notify_addr,
    output logic [ID_W-1:0]     notify_id,
    output logic [OFFSET_W-1:0] notify_offset,
    output logic [DATA_W-1:0]   notify_data,
    output logic                ready,
    output logic                initiate_request
);

    logic [STATE_W-1:0]       state;
    logic                     accept;
    logic [ADDR_W-1:0]        addr_q;
    logic [ID_W-1:0]          id_q;
    logic [OFFSET_W-1:0]      offset_q;
    logic [ROWS_W+COLW_W-1:0] cell_count;
    logic [ROWS_W+COLW_W-1:0] line_limit;
    logic                     out_of_range;
    logic [COUNT_W-1:0]       stored_count;
    logic                     line_complete;
    logic [META_W-1:0]        wb_word;

    assign ready         = (state == ST_IDLE);
    assign accept        = ready && request_valid;
    assign req_lookup    = (state == ST_LOOKUP);
    assign req_quiet     = ready && !request_valid;
    assign a_addr        = addr_q;
    assign req_addr_held = addr_q;

    // Number of lines the configured table can hold
    assign cell_count   = row_count * col_width;
    assign line_limit   = cell_count / LINE_BYTES;
    assign out_of_range = {{(ROWS_W + COLW_W - ADDR_W){1'b0}}, addr_q} >= line_limit;

    assign stored_count  = a_rdata[COUNT_LSB +: COUNT_W];
    assign line_complete = (stored_count == COUNT_W'(LINE_BYTES));

    // Record the requester and keep the count and upper bits
    always_comb
    begin
        wb_word = a_rdata;
        wb_word[ID_LSB +: ID_W] = id_q;
        wb_word[OFFSET_LSB +: OFFSET_W] = offset_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state        <= ST_IDLE;
            a_we         <= 1'b0;
            notify_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Hold off while the fill engine works on the same line
                    if (accept)
                    begin
                        state <= (request_addr == fill_addr_held) ? ST_WAIT : ST_LOOKUP;
                    end
                end
                ST_LOOKUP:
                begin
                    state <= ST_DECIDE;
                end
                ST_DECIDE:
                begin
                    notify_valid <= out_of_range || line_complete;
                    a_we         <= !out_of_range && !line_complete;
                    state        <= ST_CLEAR;
                end
                ST_CLEAR:
                begin
                    notify_valid <= 1'b0;
                    a_we         <= 1'b0;
                    state        <= ST_IDLE;
                end
                ST_WAIT:
                begin
                    if (fill_quiet)
                    begin
                        state <= ST_DECIDE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payload and reply fields
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            addr_q <= '0;
        end
        else if (accept)
        begin
            addr_q   <= request_addr;
            id_q     <= request_id;
            offset_q <= request_offset;
        end
        if (state == ST_DECIDE)
        begin
            a_wdata       <= wb_word;
            notify_id     <= id_q;
            notify_offset <= offset_q;
            // Dummy reply outside the table
            notify_addr   <= out_of_range ? '0 : addr_q;
            notify_data   <= out_of_range ? '0 : store_rdata;
        end
    end

    // Sticky once the first request has gone through
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            initiate_request <= 1'b0;
        end
        else if (accept)
        begin
            initiate_request <= 1'b1;
        end
    end

endmodule

/* hw/fill_engine.sv */
module fill_engine
    import bypass_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    // Increment events from the fetch side
    input  logic                inc,
    input  logic [ADDR_W-1:0]   inc_addr,
    input  logic [SIZE_W-1:0]   inc_size,
    input  logic [DATA_W-1:0]   inc_data,
    // Request side activity
    input  logic                request_valid,
    input  logic [ADDR_W-1:0]   request_addr,
    input  logic [ADDR_W-1:0]   req_addr_held,
    input  logic                req_lookup,
    input  logic                req_quiet,
    // Table port B
    input  logic [META_W-1:0]   b_rdata,
    output logic [ADDR_W-1:0]   b_addr,
    output logic                b_we,
    output logic [META_W-1:0]   b_wdata,
    // To the request engine
    output logic [ADDR_W-1:0]   fill_addr_held,
    output logic                fill_quiet,
    // Availability notification
    output logic                notify_valid,
    output logic [ADDR_W-1:0]   notify_addr,
    output logic [ID_W-1:0]     notify_id,
    output logic [OFFSET_W-1:0] notify_offset,
    output logic [DATA_W-1:0]   notify_data,
    output logic                data_inserted
);

    logic [STATE_W-1:0]  state;
    logic                accept;
    logic                conflict;
    logic [ADDR_W-1:0]   addr_q;
    logic [SIZE_W-1:0]   size_q;
    logic [DATA_W-1:0]   data_q;
    logic [ID_W-1:0]     stored_id;
    logic [COUNT_W-1:0]  stored_count;
    logic [OFFSET_W-1:0] stored_offset;
    logic [COUNT_W-1:0]  new_count;
    logic                release_line;
    logic [META_W-1:0]   wb_word;

    assign accept         = inc && (state == ST_IDLE);
    assign fill_quiet     = (state == ST_IDLE) || (state == ST_WAIT);
    assign data_inserted  = (state == ST_CLEAR);
    assign b_addr         = addr_q;
    assign fill_addr_held = addr_q;

    // Same line as an incoming or in-flight request
    assign conflict = (request_valid && (inc_addr == request_addr))
                   || (inc_addr == req_addr_held);

    assign stored_id     = b_rdata[ID_LSB +: ID_W];
    assign stored_count  = b_rdata[COUNT_LSB +: COUNT_W];
    assign stored_offset = b_rdata[OFFSET_LSB +: OFFSET_W];

    // Wraps at 256
    assign new_count    = stored_count + size_q;
    assign release_line = (new_count >= COUNT_W'(LINE_BYTES)) && (stored_id != '0);

    always_comb
    begin
        wb_word = b_rdata;
        wb_word[COUNT_LSB +: COUNT_W] = new_count;
        if (release_line)
        begin
            wb_word[ID_LSB +: ID_W] = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state        <= ST_IDLE;
            b_we         <= 1'b0;
            notify_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        state <= conflict ? ST_WAIT : ST_LOOKUP;
                    end
                end
                ST_LOOKUP:
                begin
                    // Let a request lookup go first
                    if (!req_lookup)
                    begin
                        state <= ST_DECIDE;
                    end
                end
                ST_DECIDE:
                begin
                    b_we         <= 1'b1;
                    notify_valid <= release_line;
                    state        <= ST_CLEAR;
                end
                ST_CLEAR:
                begin
                    b_we         <= 1'b0;
                    notify_valid <= 1'b0;
                    state        <= ST_IDLE;
                end
                ST_WAIT:
                begin
                    if (req_quiet)
                    begin
                        state <= ST_DECIDE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Increment payload and release fields
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            addr_q <= '0;
        end
        else if (accept)
        begin
            addr_q <= inc_addr;
            size_q <= inc_size;
            data_q <= inc_data;
        end
        if (state == ST_DECIDE)
        begin
            b_wdata       <= wb_word;
            notify_addr   <= addr_q;
            notify_id     <= stored_id;
            notify_offset <= stored_offset;
            notify_data   <= data_q;
        end
    end

endmodule

/* hw/monitor_bypass.sv */
module monitor_bypass
    import bypass_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    // Request notifications
    input  logic                request_valid,
    input  logic [ADDR_W-1:0]   request_addr,
    input  logic [ID_W-1:0]     request_id,
    input  logic [OFFSET_W-1:0] request_offset,
    // Increment events
    input  logic                inc,
    input  logic [ADDR_W-1:0]   inc_addr,
    input  logic [SIZE_W-1:0]   inc_size,
    input  logic [DATA_W-1:0]   inc_data,
    // Line data writes
    input  logic                fill_en,
    input  logic [ADDR_W-1:0]   fill_addr,
    input  logic [DATA_W-1:0]   fill_data,
    // Configuration
    input  logic [ROWS_W-1:0]   row_count,
    input  logic [COLW_W-1:0]   col_width,
    // Availability notification
    output logic                avail_valid,
    output logic [ADDR_W-1:0]   avail_addr,
    output logic [ID_W-1:0]     avail_id,
    output logic [OFFSET_W-1:0] avail_offset,
    output logic [DATA_W-1:0]   avail_data,
    output logic                ready,
    output logic                initiate_request,
    output logic                data_inserted
);

    logic [ADDR_W-1:0]   a_addr;
    logic                a_we;
    logic [META_W-1:0]   a_wdata;
    logic [META_W-1:0]   a_rdata;
    logic [ADDR_W-1:0]   b_addr;
    logic                b_we;
    logic [META_W-1:0]   b_wdata;
    logic [META_W-1:0]   b_rdata;
    logic [DATA_W-1:0]   store_rdata;
    logic [ADDR_W-1:0]   req_addr_held;
    logic                req_lookup;
    logic                req_quiet;
    logic [ADDR_W-1:0]   fill_addr_held;
    logic                fill_quiet;

    // Per engine notifications
    logic                re_valid;
    logic [ADDR_W-1:0]   re_addr;
    logic [ID_W-1:0]     re_id;
    logic [OFFSET_W-1:0] re_offset;
    logic [DATA_W-1:0]   re_data;
    logic                fe_valid;
    logic [ADDR_W-1:0]   fe_addr;
    logic [ID_W-1:0]     fe_id;
    logic [OFFSET_W-1:0] fe_offset;
    logic [DATA_W-1:0]   fe_data;

    line_table i_line_table (
        .clock   (clock),
        .a_addr  (a_addr),
        .a_we    (a_we),
        .a_wdata (a_wdata),
        .a_rdata (a_rdata),
        .b_addr  (b_addr),
        .b_we    (b_we),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata)
    );

    line_store i_line_store (
        .clock     (clock),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .rd_addr   (req_addr_held),
        .rd_data   (store_rdata)
    );

    request_engine i_request_engine (
        .clock            (clock),
        .reset            (reset),
        .request_valid    (request_valid),
        .request_addr     (request_addr),
        .request_id       (request_id),
        .request_offset   (request_offset),
        .row_count        (row_count),
        .col_width        (col_width),
        .a_rdata          (a_rdata),
        .store_rdata      (store_rdata),
        .fill_addr_held   (fill_addr_held),
        .fill_quiet       (fill_quiet),
        .a_addr           (a_addr),
        .a_we             (a_we),
        .a_wdata          (a_wdata),
        .req_addr_held    (req_addr_held),
        .req_lookup       (req_lookup),
        .req_quiet        (req_quiet),
        .notify_valid     (re_valid),
        .notify_addr      (re_addr),
        .notify_id        (re_id),
        .notify_offset    (re_offset),
        .notify_data      (re_data),
        .ready            (ready),
        .initiate_request (initiate_request)
    );

    fill_engine i_fill_engine (
        .clock          (clock),
        .reset          (reset),
        .inc            (inc),
        .inc_addr       (inc_addr),
        .inc_size       (inc_size),
        .inc_data       (inc_data),
        .request_valid  (request_valid),
        .request_addr   (request_addr),
        .req_addr_held  (req_addr_held),
        .req_lookup     (req_lookup),
        .req_quiet      (req_quiet),
        .b_rdata        (b_rdata),
        .b_addr         (b_addr),
        .b_we           (b_we),
        .b_wdata        (b_wdata),
        .fill_addr_held (fill_addr_held),
        .fill_quiet     (fill_quiet),
        .notify_valid   (fe_valid),
        .notify_addr    (fe_addr),
        .notify_id      (fe_id),
        .notify_offset  (fe_offset),
        .notify_data    (fe_data),
        .data_inserted  (data_inserted)
    );

    // Request side wins when both notify in the same cycle
    assign avail_valid  = re_valid | fe_valid;
    assign avail_addr   = re_valid ? re_addr : fe_addr;
    assign avail_id     = re_valid ? re_id : fe_id;
    assign avail_offset = re_valid ? re_offset : fe_offset;
    assign avail_data   = re_valid ? re_data : fe_data;

endmodule

/* tests/tb_monitor_bypass.sv */
module tb_monitor_bypass
    import bypass_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TABLE_LINES  = 16;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_OPS   = 40;
    localparam int CYCLE_LIMIT  = 5000;
    localparam int EXP_DEPTH    = 256;

    logic                clock;
    logic                reset;
    logic                request_valid;
    logic [ADDR_W-1:0]   request_addr;
    logic [ID_W-1:0]     request_id;
    logic [OFFSET_W-1:0] request_offset;
    logic                inc;
    logic [ADDR_W-1:0]   inc_addr;
    logic [SIZE_W-1:0]   inc_size;
    logic [DATA_W-1:0]   inc_data;
    logic                fill_en;
    logic [ADDR_W-1:0]   fill_addr;
    logic [DATA_W-1:0]   fill_data;
    logic [ROWS_W-1:0]   row_count;
    logic [COLW_W-1:0]   col_width;
    logic                avail_valid;
    logic [ADDR_W-1:0]   avail_addr;
    logic [ID_W-1:0]     avail_id;
    logic [OFFSET_W-1:0] avail_offset;
    logic [DATA_W-1:0]   avail_data;
    logic                ready;
    logic                initiate_request;
    logic                data_inserted;

    // Reference model of each line inside the limit
    logic [COUNT_W-1:0]  line_count  [0:TABLE_LINES-1];
    logic [ID_W-1:0]     line_id     [0:TABLE_LINES-1];
    logic [OFFSET_W-1:0] line_offset [0:TABLE_LINES-1];
    logic [DATA_W-1:0]   line_data   [0:TABLE_LINES-1];

    // Expected notifications in arrival order
    logic [ADDR_W-1:0]   exp_addr   [0:EXP_DEPTH-1];
    logic [ID_W-1:0]     exp_id     [0:EXP_DEPTH-1];
    logic [OFFSET_W-1:0] exp_offset [0:EXP_DEPTH-1];
    logic [DATA_W-1:0]   exp_data   [0:EXP_DEPTH-1];
    int                  wr_ptr = 0;
    int                  rd_ptr = 0;

    logic [31:0] lcg_state = 32'd90409;
    logic        inc_outstanding;
    logic        drain_check;
    int          errors      = 0;
    int          cycles      = 0;
    int          seen_notify = 0;
    int          inc_total   = 0;

    monitor_bypass i_monitor_bypass (
        .clock            (clock),
        .reset            (reset),
        .request_valid    (request_valid),
        .request_addr     (request_addr),
        .request_id       (request_id),
        .request_offset   (request_offset),
        .inc              (inc),
        .inc_addr         (inc_addr),
        .inc_size         (inc_size),
        .inc_data         (inc_data),
        .fill_en          (fill_en),
        .fill_addr        (fill_addr),
        .fill_data        (fill_data),
        .row_count        (row_count),
        .col_width        (col_width),
        .avail_valid      (avail_valid),
        .avail_addr       (avail_addr),
        .avail_id         (avail_id),
        .avail_offset     (avail_offset),
        .avail_data       (avail_data),
        .ready            (ready),
        .initiate_request (initiate_request),
        .data_inserted    (data_inserted)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #5 clock = ~clock;
        end
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Retire the head entry once a notification has been seen
    always @(posedge clock)
    begin
        if (!reset && avail_valid)
        begin
            seen_notify <= seen_notify + 1;
            if (rd_ptr != wr_ptr)
            begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    reset_idle: assert property (@(posedge clock) $past(reset) && !reset
        |-> ready && !avail_valid && !data_inserted && !initiate_request)
    else
    begin
        errors++;
        $display("mismatch at %0t: outputs not idle right after reset", $time);
    end

    initiate_set: assert property (@(posedge clock) disable iff (reset)
        $past(ready && request_valid) || $past(initiate_request) |-> initiate_request)
    else
    begin
        errors++;
        $display("mismatch at %0t: initiate_request low after a request", $time);
    end

    notify_expected: assert property (@(posedge clock) disable iff (reset)
        avail_valid |-> rd_ptr != wr_ptr)
    else
    begin
        errors++;
        $display("unexpected notification for line %0h at %0t", $sampled(avail_addr), $time);
    end

    notify_fields: assert property (@(posedge clock) disable iff (reset)
        avail_valid && rd_ptr != wr_ptr
        |-> avail_addr == exp_addr[rd_ptr] && avail_id == exp_id[rd_ptr]
            && avail_offset == exp_offset[rd_ptr] && avail_data == exp_data[rd_ptr])
    else
    begin
        errors++;
        $display("mismatch at %0t: got addr %0h id %0h offset %0h data %0h", $time,
                 $sampled(avail_addr), $sampled(avail_id), $sampled(avail_offset),
                 $sampled(avail_data));
        $display("  expected addr %0h id %0h offset %0h data %0h",
                 exp_addr[$sampled(rd_ptr)], exp_id[$sampled(rd_ptr)],
                 exp_offset[$sampled(rd_ptr)], exp_data[$sampled(rd_ptr)]);
    end

    notify_single: assert property (@(posedge clock) disable iff (reset)
        $past(avail_valid) |-> !avail_valid)
    else
    begin
        errors++;
        $display("mismatch at %0t: avail_valid held longer than one cycle", $time);
    end

    inserted_expected: assert property (@(posedge clock) disable iff (reset)
        data_inserted |-> inc_outstanding)
    else
    begin
        errors++;
        $display("data_inserted pulsed with no increment pending at %0t", $time);
    end

    drained: assert property (@(posedge clock) drain_check |-> rd_ptr == wr_ptr)
    else
    begin
        errors++;
        $display("missing notification: %0d expected but never seen at %0t",
                 $sampled(wr_ptr) - $sampled(rd_ptr), $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Model and stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [DATA_W-1:0] random_data();
        logic [DATA_W-1:0] word;
        for (int i = 0; i < DATA_W / 16; i++)
        begin
            word[i*16 +: 16] = next_rand();
        end
        return word;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic push_expected(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                                 input logic [OFFSET_W-1:0] offset,
                                 input logic [DATA_W-1:0] data);
        exp_addr[wr_ptr]   = addr;
        exp_id[wr_ptr]     = id;
        exp_offset[wr_ptr] = offset;
        exp_data[wr_ptr]   = data;
        wr_ptr++;
    endtask

    // Complete line answers at once, otherwise the requester is recorded
    task automatic model_request(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                                 input logic [OFFSET_W-1:0] offset);
        if (addr >= TABLE_LINES)
        begin
            push_expected('0, id, offset, '0);
        end
        else if (line_count[addr] == LINE_BYTES)
        begin
            push_expected(addr, id, offset, line_data[addr]);
        end
        else
        begin
            line_id[addr]     = id;
            line_offset[addr] = offset;
        end
    endtask

    task automatic model_inc(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                             input logic [DATA_W-1:0] data);
        logic [COUNT_W-1:0] sum;
        sum = line_count[addr] + size;
        if (sum >= LINE_BYTES && line_id[addr] != '0)
        begin
            push_expected(addr, line_id[addr], line_offset[addr], data);
            line_id[addr] = '0;
        end
        line_count[addr] = sum;
    endtask

    // Held until ready, released after the accepting edge
    task automatic drive_request(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                                 input logic [OFFSET_W-1:0] offset);
        request_valid  = 1'b1;
        request_addr   = addr;
        request_id     = id;
        request_offset = offset;
        while (!ready)
        begin
            next_cycle();
        end
        next_cycle();
        request_valid = 1'b0;
    endtask

    task automatic finish_request();
        while (!ready)
        begin
            next_cycle();
        end
    endtask

    task automatic drive_inc(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                             input logic [DATA_W-1:0] data);
        inc             = 1'b1;
        inc_addr        = addr;
        inc_size        = size;
        inc_data        = data;
        inc_outstanding = 1'b1;
        inc_total++;
        next_cycle();
        inc = 1'b0;
    endtask

    task automatic finish_inc();
        while (!data_inserted)
        begin
            next_cycle();
        end
        next_cycle();
        inc_outstanding = 1'b0;
    endtask

    task automatic check_drained();
        drain_check = 1'b1;
        next_cycle();
        drain_check = 1'b0;
    endtask

    task automatic do_request(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                              input logic [OFFSET_W-1:0] offset);
        model_request(addr, id, offset);
        drive_request(addr, id, offset);
        finish_request();
        check_drained();
    endtask

    task automatic do_inc(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size,
                          input logic [DATA_W-1:0] data);
        model_inc(addr, size, data);
        drive_inc(addr, size, data);
        finish_inc();
        check_drained();
    endtask

    // Inc lands while the request on the same line is still in flight
    task automatic do_request_then_inc(input logic [ADDR_W-1:0] addr,
                                       input logic [ID_W-1:0] id,
                                       input logic [OFFSET_W-1:0] offset,
                                       input logic [SIZE_W-1:0] size,
                                       input logic [DATA_W-1:0] data);
        model_request(addr, id, offset);
        model_inc(addr, size, data);
        drive_request(addr, id, offset);
        drive_inc(addr, size, data);
        finish_request();
        finish_inc();
        check_drained();
    endtask

    task automatic write_line_data(input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data);
        fill_en         = 1'b1;
        fill_addr       = addr;
        fill_data       = data;
        line_data[addr] = data;
        next_cycle();
        fill_en = 1'b0;
    endtask

    initial
    begin
        int                  op;
        logic [ADDR_W-1:0]   line;
        logic [ID_W-1:0]     id;
        logic [OFFSET_W-1:0] offset;
        logic [SIZE_W-1:0]   size;

        reset           = 1'b1;
        request_valid   = 1'b0;
        request_addr    = '0;
        request_id      = '0;
        request_offset  = '0;
        inc             = 1'b0;
        inc_addr        = '0;
        inc_size        = '0;
        inc_data        = '0;
        fill_en         = 1'b0;
        fill_addr       = '0;
        fill_data       = '0;
        row_count       = 32'd16;
        col_width       = 16'd64;
        inc_outstanding = 1'b0;
        drain_check     = 1'b0;
        for (int i = 0; i < TABLE_LINES; i++)
        begin
            line_count[i]  = '0;
            line_id[i]     = '0;
            line_offset[i] = '0;
        end

        repeat (RESET_CYCLES)
        begin
            next_cycle();
        end
        reset = 1'b0;
        next_cycle();

        // Line data for every line inside the limit
        for (int i = 0; i < TABLE_LINES; i++)
        begin
            write_line_data(ADDR_W'(i), random_data());
        end

        // Pending requester released by one full increment
        do_request(10'd3, 16'h1234, 2'd1);
        do_inc(10'd3, 8'd64, random_data());

        // Two halves, only a pending id is released
        do_request(10'd5, 16'h00a5, 2'd2);
        do_inc(10'd5, 8'd32, random_data());
        do_inc(10'd5, 8'd32, random_data());
        do_inc(10'd6, 8'd32, random_data());
        do_inc(10'd6, 8'd32, random_data());

        // Complete line answers straight from the store
        write_line_data(10'd6, random_data());
        do_request(10'd6, 16'hbeef, 2'd3);

        // Beyond the limit
        do_request(10'd16, 16'h0042, 2'd0);
        do_request(10'd1023, 16'h7001, 2'd1);

        // Same line from both sides at once
        do_inc(10'd9, 8'd32, random_data());
        do_request_then_inc(10'd9, 16'h0c0d, 2'd2, 8'd32, random_data());
        do_request_then_inc(10'd10, 16'h0e0f, 2'd1, 8'd64, random_data());

        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            op     = next_rand() % 5;
            line   = ADDR_W'(next_rand() % TABLE_LINES);
            id     = next_rand() | 16'd1;
            offset = OFFSET_W'(next_rand());
            size   = SIZE_W'(16 * (1 + next_rand() % 4));
            case (op)
                0: do_request(line, id, offset);
                1: do_request(ADDR_W'(TABLE_LINES + next_rand() % (LINES - TABLE_LINES)),
                              id, offset);
                2: do_inc(line, size, random_data());
                3: write_line_data(line, random_data());
                default: do_request_then_inc(line, id, offset, size, random_data());
            endcase
        end

        check_drained();
        $display("summary: %0d notifications, %0d increments, %0d errors",
                 seen_notify, inc_total, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/bypass_pkg.sv
hw/line_table.sv
hw/line_store.sv
hw/request_engine.sv
hw/fill_engine.sv
hw/monitor_bypass.sv
tests/tb_monitor_bypass.sv

/* Makefile */
# Verilator build and run of the bypass line monitor testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_monitor_bypass \
		-f sim.f -Mdir obj_dir -o sim_monitor_bypass

# The log decides the outcome
run: compile
	./obj_dir/sim_monitor_bypass > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
